/* hdl/riscv_pkg.sv */
//////////////////////////////////////////////////
// Opcode encodings shared by the vector logical
// unit and its testbench
//////////////////////////////////////////////////

package riscv_pkg;

    // OPIVV funct6 values handled by the logical slice
    typedef enum logic [5:0] {
        VAND = 6'b001001,
        VOR  = 6'b001010,
        VXOR = 6'b001011,
        VSLL = 6'b100101,
        VSRL = 6'b101000,
        VSRA = 6'b101001
    } funct6_e;

    // Not decoded by this unit, drives the illegal path
    localparam logic [5:0] FUNCT6_ILLEGAL = 6'b111111;

endpackage : riscv_pkg

/* hdl/riscv_v_pkg.sv */
//////////////////////////////////////////////////
// Vector datapath types: element width, lane data
// and per-byte element size vectors
//////////////////////////////////////////////////

package riscv_v_pkg;

    localparam int LANE_BYTES_DEF = 8;

    typedef enum logic [1:0] {
        E8  = 2'd0,
        E16 = 2'd1,
        E32 = 2'd2,
        E64 = 2'd3
    } sew_e;

    typedef logic [LANE_BYTES_DEF*8-1:0] lane_data_t;

    // One bit per byte, set on the top byte of each element
    typedef logic [LANE_BYTES_DEF-1:0] osize_vector_t;

    // Shift amount width is log2(SEW)
    function automatic int shamt_bits(sew_e sew);
        return 3 + int'(sew);
    endfunction

    // Pattern for one 64-bit chunk, repeats across wider lanes
    function automatic osize_vector_t osize_pattern(sew_e sew);
        osize_vector_t v;
        for (int i = 0; i < LANE_BYTES_DEF; i++) begin
            v[i] = (((i + 1) % (1 << int'(sew))) == 0);
        end
        return v;
    endfunction

endpackage : riscv_v_pkg

/* hdl/riscv_v_decode.sv */
//////////////////////////////////////////////////
// Decode stage: turns funct6 into operation flags,
// builds byte size and write enable vectors
//////////////////////////////////////////////////

module riscv_v_decode #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  riscv_pkg::funct6_e      funct6,
    input  riscv_v_pkg::sew_e       vsew,
    input  logic                    vm,
    input  logic [LANE_BYTES-1:0]   v0_mask,
    input  logic [LANE_BYTES*8-1:0] vs2,
    input  logic [LANE_BYTES*8-1:0] vs1,
    input  logic [LANE_BYTES*8-1:0] vd_old,
    output logic                    d_valid,
    output logic                    d_is_and,
    output logic                    d_is_or,
    output logic                    d_is_xor,
    output logic                    d_is_shift,
    output logic                    d_is_left,
    output logic                    d_is_arith,
    output logic                    d_illegal,
    output logic [LANE_BYTES-1:0]   d_osize_vector,
    output logic [LANE_BYTES-1:0]   d_byte_we,
    output logic [LANE_BYTES*8-1:0] d_srca,
    output logic [LANE_BYTES*8-1:0] d_srcb,
    output logic [LANE_BYTES*8-1:0] d_vd_old
);
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    logic                  is_and;
    logic                  is_or;
    logic                  is_xor;
    logic                  is_shift;
    logic                  is_left;
    logic                  is_arith;
    logic                  illegal;
    logic [LANE_BYTES-1:0] byte_we;

    always_comb begin
        is_and   = 1'b0;
        is_or    = 1'b0;
        is_xor   = 1'b0;
        is_shift = 1'b0;
        is_left  = 1'b0;
        is_arith = 1'b0;
        illegal  = 1'b0;
        case (funct6)
            VAND: is_and = 1'b1;
            VOR:  is_or  = 1'b1;
            VXOR: is_xor = 1'b1;
            VSLL: begin
                is_shift = 1'b1;
                is_left  = 1'b1;
            end
            VSRL: is_shift = 1'b1;
            VSRA: begin
                is_shift = 1'b1;
                is_arith = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // v0 holds one bit per element
    always_comb begin
        for (int i = 0; i < LANE_BYTES; i++) begin
            if (illegal)
                byte_we[i] = 1'b0;
            else if (vm)
                byte_we[i] = 1'b1;
            else
                byte_we[i] = v0_mask[i >> vsew];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid   <= 1'b0;
            d_illegal <= 1'b0;
        end else begin
            d_valid   <= in_valid;
            d_illegal <= in_valid & illegal;
        end
    end

    always_ff @(posedge clk) begin
        d_is_and       <= is_and;
        d_is_or        <= is_or;
        d_is_xor       <= is_xor;
        d_is_shift     <= is_shift;
        d_is_left      <= is_left;
        d_is_arith     <= is_arith;
        d_osize_vector <= {(LANE_BYTES / LANE_BYTES_DEF){osize_pattern(vsew)}};
        d_byte_we      <= byte_we;
        d_srca         <= vs2;
        d_srcb         <= vs1;
        d_vd_old       <= vd_old;
    end

endmodule : riscv_v_decode

/* hdl/riscv_v_bw_logic.sv */
//////////////////////////////////////////////////
// Lane-wide AND/OR/XOR, zero when no bitwise
// operation is selected
//////////////////////////////////////////////////

module riscv_v_bw_logic #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input  logic                    is_and,
    input  logic                    is_or,
    input  logic                    is_xor,
    input  logic [LANE_BYTES*8-1:0] srca,
    input  logic [LANE_BYTES*8-1:0] srcb,
    output logic [LANE_BYTES*8-1:0] result
);

    logic [LANE_BYTES*8-1:0] and_res;
    logic [LANE_BYTES*8-1:0] or_res;
    logic [LANE_BYTES*8-1:0] xor_res;

    // Element width plays no part in bitwise ops
    assign and_res = srca & srcb;
    assign or_res  = srca | srcb;
    assign xor_res = srca ^ srcb;

    always_comb begin
        if (is_and)
            result = and_res;
        else if (is_or)
            result = or_res;
        else if (is_xor)
            result = xor_res;
        else
            result = '0;
    end

endmodule : riscv_v_bw_logic

/* hdl/riscv_v_shifter.sv */
//////////////////////////////////////////////////
// Per-element shifter for SEW 8 to 64; element
// size is taken from the byte size vector
//////////////////////////////////////////////////

module riscv_v_shifter #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input  logic                    is_shift,
    input  logic                    is_left,
    input  logic                    is_arith,
    input  logic [LANE_BYTES-1:0]   osize_vector,
    input  logic [LANE_BYTES*8-1:0] srca,
    input  logic [LANE_BYTES*8-1:0] srcb,
    output logic [LANE_BYTES*8-1:0] result
);
    import riscv_v_pkg::*;

    localparam int DATA_W = LANE_BYTES * 8;

    sew_e              sew;
    wire  [DATA_W-1:0] cand [4];

    // Smallest element whose top byte lands on a set bit
    always_comb begin
        if (osize_vector[0])
            sew = E8;
        else if (osize_vector[1])
            sew = E16;
        else if (osize_vector[3])
            sew = E32;
        else
            sew = E64;
    end

    // One candidate result per element width
    for (genvar k = 0; k < 4; k++) begin : g_width
        localparam int W  = 8 << k;
        localparam int SH = shamt_bits(sew_e'(k));

        for (genvar e = 0; e < DATA_W / W; e++) begin : g_elem
            logic [W-1:0]  a;
            logic [SH-1:0] sh;
            logic [W-1:0]  sra;

            assign a   = srca[e*W +: W];
            assign sh  = srcb[e*W +: SH];
            // Sign fill from the element's top bit
            assign sra = $signed(a) >>> sh;
            assign cand[k][e*W +: W] = is_left  ? (a << sh) :
                                       is_arith ? sra : (a >> sh);
        end
    end

    assign result = is_shift ? cand[sew] : '0;

endmodule : riscv_v_shifter

/* hdl/riscv_v_logic_alu.sv */
//////////////////////////////////////////////////
// ALU stage: bitwise and shift units side by side,
// result registered with the writeback controls
//////////////////////////////////////////////////

module riscv_v_logic_alu #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    d_valid,
    input  logic                    d_is_and,
    input  logic                    d_is_or,
    input  logic                    d_is_xor,
    input  logic                    d_is_shift,
    input  logic                    d_is_left,
    input  logic                    d_is_arith,
    input  logic                    d_illegal,
    input  logic [LANE_BYTES-1:0]   d_osize_vector,
    input  logic [LANE_BYTES-1:0]   d_byte_we,
    input  logic [LANE_BYTES*8-1:0] d_srca,
    input  logic [LANE_BYTES*8-1:0] d_srcb,
    input  logic [LANE_BYTES*8-1:0] d_vd_old,
    output logic                    a_valid,
    output logic                    a_illegal,
    output logic [LANE_BYTES*8-1:0] a_result,
    output logic [LANE_BYTES-1:0]   a_byte_we,
    output logic [LANE_BYTES*8-1:0] a_vd_old
);

    logic [LANE_BYTES*8-1:0] bw_result;
    logic [LANE_BYTES*8-1:0] sh_result;

    riscv_v_bw_logic #(
        .LANE_BYTES(LANE_BYTES)
    ) bw_i (
        .is_and(d_is_and),
        .is_or (d_is_or),
        .is_xor(d_is_xor),
        .srca  (d_srca),
        .srcb  (d_srcb),
        .result(bw_result)
    );

    riscv_v_shifter #(
        .LANE_BYTES(LANE_BYTES)
    ) shifter_i (
        .is_shift    (d_is_shift),
        .is_left     (d_is_left),
        .is_arith    (d_is_arith),
        .osize_vector(d_osize_vector),
        .srca        (d_srca),
        .srcb        (d_srcb),
        .result      (sh_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_valid   <= 1'b0;
            a_illegal <= 1'b0;
        end else begin
            a_valid   <= d_valid;
            a_illegal <= d_illegal;
        end
    end

    // Unselected unit drives zero
    always_ff @(posedge clk) begin
        a_result  <= bw_result | sh_result;
        a_byte_we <= d_byte_we;
        a_vd_old  <= d_vd_old;
    end

endmodule : riscv_v_logic_alu

/* hdl/riscv_v_writeback.sv */
//////////////////////////////////////////////////
// Writeback stage: byte merge of result and old
// destination, registered onto the outputs
//////////////////////////////////////////////////

module riscv_v_writeback #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    a_valid,
    input  logic                    a_illegal,
    input  logic [LANE_BYTES*8-1:0] a_result,
    input  logic [LANE_BYTES-1:0]   a_byte_we,
    input  logic [LANE_BYTES*8-1:0] a_vd_old,
    output logic                    out_valid,
    output logic                    out_illegal,
    output logic [LANE_BYTES*8-1:0] out_data
);

    logic [LANE_BYTES*8-1:0] merged;

    // Masked-off bytes stay undisturbed
    always_comb begin
        for (int i = 0; i < LANE_BYTES; i++) begin
            merged[i*8 +: 8] = a_byte_we[i] ? a_result[i*8 +: 8] : a_vd_old[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
        end else begin
            out_valid   <= a_valid;
            out_illegal <= a_illegal;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= merged;
    end

endmodule : riscv_v_writeback

/* hdl/riscv_v_logic_unit.sv */
//////////////////////////////////////////////////
// Vector logical/shift slice for one lane, three
// stages, one operation per cycle, latency 3
//////////////////////////////////////////////////

module riscv_v_logic_unit #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  riscv_pkg::funct6_e      funct6,
    input  riscv_v_pkg::sew_e       vsew,
    input  logic                    vm,
    input  logic [LANE_BYTES-1:0]   v0_mask,
    input  logic [LANE_BYTES*8-1:0] vs2,
    input  logic [LANE_BYTES*8-1:0] vs1,
    input  logic [LANE_BYTES*8-1:0] vd_old,
    output logic                    out_valid,
    output logic                    out_illegal,
    output logic [LANE_BYTES*8-1:0] out_data
);

    logic                    d_valid;
    logic                    d_is_and;
    logic                    d_is_or;
    logic                    d_is_xor;
    logic                    d_is_shift;
    logic                    d_is_left;
    logic                    d_is_arith;
    logic                    d_illegal;
    logic [LANE_BYTES-1:0]   d_osize_vector;
    logic [LANE_BYTES-1:0]   d_byte_we;
    logic [LANE_BYTES*8-1:0] d_srca;
    logic [LANE_BYTES*8-1:0] d_srcb;
    logic [LANE_BYTES*8-1:0] d_vd_old;

    logic                    a_valid;
    logic                    a_illegal;
    logic [LANE_BYTES*8-1:0] a_result;
    logic [LANE_BYTES-1:0]   a_byte_we;
    logic [LANE_BYTES*8-1:0] a_vd_old;

    riscv_v_decode #(
        .LANE_BYTES(LANE_BYTES)
    ) decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .funct6        (funct6),
        .vsew          (vsew),
        .vm            (vm),
        .v0_mask       (v0_mask),
        .vs2           (vs2),
        .vs1           (vs1),
        .vd_old        (vd_old),
        .d_valid       (d_valid),
        .d_is_and      (d_is_and),
        .d_is_or       (d_is_or),
        .d_is_xor      (d_is_xor),
        .d_is_shift    (d_is_shift),
        .d_is_left     (d_is_left),
        .d_is_arith    (d_is_arith),
        .d_illegal     (d_illegal),
        .d_osize_vector(d_osize_vector),
        .d_byte_we     (d_byte_we),
        .d_srca        (d_srca),
        .d_srcb        (d_srcb),
        .d_vd_old      (d_vd_old)
    );

    riscv_v_logic_alu #(
        .LANE_BYTES(LANE_BYTES)
    ) alu_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_valid       (d_valid),
        .d_is_and      (d_is_and),
        .d_is_or       (d_is_or),
        .d_is_xor      (d_is_xor),
        .d_is_shift    (d_is_shift),
        .d_is_left     (d_is_left),
        .d_is_arith    (d_is_arith),
        .d_illegal     (d_illegal),
        .d_osize_vector(d_osize_vector),
        .d_byte_we     (d_byte_we),
        .d_srca        (d_srca),
        .d_srcb        (d_srcb),
        .d_vd_old      (d_vd_old),
        .a_valid       (a_valid),
        .a_illegal     (a_illegal),
        .a_result      (a_result),
        .a_byte_we     (a_byte_we),
        .a_vd_old      (a_vd_old)
    );

    riscv_v_writeback #(
        .LANE_BYTES(LANE_BYTES)
    ) wb_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_valid    (a_valid),
        .a_illegal  (a_illegal),
        .a_result   (a_result),
        .a_byte_we  (a_byte_we),
        .a_vd_old   (a_vd_old),
        .out_valid  (out_valid),
        .out_illegal(out_illegal),
        .out_data   (out_data)
    );

endmodule : riscv_v_logic_unit

/* verification/riscv_v_logic_checker.sv */
//////////////////////////////////////////////////
// Assertions bound into the vector logical unit,
// checked against a reference model of the lane
//////////////////////////////////////////////////

module riscv_v_logic_checker #(
    parameter int LANE_BYTES = riscv_v_pkg::LANE_BYTES_DEF
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    in_valid,
    input riscv_pkg::funct6_e      funct6,
    input riscv_v_pkg::sew_e       vsew,
    input logic                    vm,
    input logic [LANE_BYTES-1:0]   v0_mask,
    input logic [LANE_BYTES*8-1:0] vs2,
    input logic [LANE_BYTES*8-1:0] vs1,
    input logic [LANE_BYTES*8-1:0] vd_old,
    input logic                    out_valid,
    input logic                    out_illegal,
    input logic [LANE_BYTES*8-1:0] out_data
);
    import riscv_pkg::*;

    localparam int DATA_W = LANE_BYTES * 8;

    int unsigned       fail_count = 0;
    int unsigned       cycles = 0;
    logic [DATA_W-1:0] exp_now;
    logic              exp_illegal_now;
    logic [DATA_W-1:0] exp_data_q [3];
    logic              exp_illegal_q [3];
    logic              exp_valid_q [3];

    function automatic logic is_legal(input logic [5:0] f6);
        return f6 inside {VAND, VOR, VXOR, VSLL, VSRL, VSRA};
    endfunction

    // Expected lane value from the ISA rules
    function automatic logic [DATA_W-1:0] ref_lane(
        input logic [5:0]            f6,
        input logic [1:0]            sew,
        input logic                  vm_bit,
        input logic [LANE_BYTES-1:0] v0,
        input logic [DATA_W-1:0]     a,
        input logic [DATA_W-1:0]     b,
        input logic [DATA_W-1:0]     old
    );
        logic [DATA_W-1:0] op;
        logic [DATA_W-1:0] merged;
        logic [63:0]       ea;
        logic [63:0]       eb;
        logic [63:0]       er;
        logic [63:0]       emask;
        int                ew;
        int                sh;

        if (!is_legal(f6))
            return old;
        ew = 8 << sew;
        emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        op = '0;
        for (int e = 0; e < DATA_W / ew; e++) begin
            ea = 64'(a >> (e * ew)) & emask;
            eb = 64'(b >> (e * ew)) & emask;
            // Low log2(SEW) bits of the vs1 element
            sh = int'(eb[5:0]) % ew;
            case (f6)
                VAND: er = ea & eb;
                VOR:  er = ea | eb;
                VXOR: er = ea ^ eb;
                VSLL: er = (ea << sh) & emask;
                VSRL: er = ea >> sh;
                default: begin
                    er = ea >> sh;
                    if (ea[ew-1])
                        er = er | (emask & ~(emask >> sh));
                end
            endcase
            op = op | (DATA_W'(er) << (e * ew));
        end
        for (int i = 0; i < LANE_BYTES; i++) begin
            merged[i*8 +: 8] = (vm_bit || v0[i / (ew / 8)]) ? op[i*8 +: 8] : old[i*8 +: 8];
        end
        return merged;
    endfunction

    always_comb begin
        exp_now         = ref_lane(funct6, vsew, vm, v0_mask, vs2, vs1, vd_old);
        exp_illegal_now = in_valid && !is_legal(funct6);
    end

    // Hold the expectation for the three pipeline stages
    always @(posedge clk) begin
        cycles           <= cycles + 1;
        exp_data_q[0]    <= exp_now;
        exp_data_q[1]    <= exp_data_q[0];
        exp_data_q[2]    <= exp_data_q[1];
        exp_illegal_q[0] <= exp_illegal_now;
        exp_illegal_q[1] <= exp_illegal_q[0];
        exp_illegal_q[2] <= exp_illegal_q[1];
        exp_valid_q[0]   <= in_valid;
        exp_valid_q[1]   <= exp_valid_q[0];
        exp_valid_q[2]   <= exp_valid_q[1];
    end

    // Outputs idle right after any reset cycle
    assert property (@(posedge clk) disable iff (cycles < 2)
        !$past(rst_n) |-> (!out_valid && !out_illegal))
    else begin
        $error("out_valid or out_illegal is set in the cycle after reset");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n || cycles < 4)
        out_valid == exp_valid_q[2])
    else begin
        $error("Mismatch out_valid expected %h actual %h",
               $sampled(exp_valid_q[2]), $sampled(out_valid));
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n || cycles < 4)
        out_illegal == exp_illegal_q[2])
    else begin
        $error("Mismatch out_illegal expected %h actual %h",
               $sampled(exp_illegal_q[2]), $sampled(out_illegal));
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_data == exp_data_q[2]))
    else begin
        $error("Mismatch out_data expected %h actual %h",
               $sampled(exp_data_q[2]), $sampled(out_data));
        fail_count++;
    end

endmodule : riscv_v_logic_checker

bind riscv_v_logic_unit riscv_v_logic_checker #(
    .LANE_BYTES(LANE_BYTES)
) checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .funct6     (funct6),
    .vsew       (vsew),
    .vm         (vm),
    .v0_mask    (v0_mask),
    .vs2        (vs2),
    .vs1        (vs1),
    .vd_old     (vd_old),
    .out_valid  (out_valid),
    .out_illegal(out_illegal),
    .out_data   (out_data)
);

/* verification/riscv_v_logic_tb.sv */
//////////////////////////////////////////////////
// Testbench for the vector logical unit; drives
// LFSR operands, the bound checker does the checks
//////////////////////////////////////////////////

module riscv_v_logic_tb;
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_OPS     = 300;
    localparam int NUM_ILLEGAL = 6;
    localparam int TOTAL_OPS   = NUM_OPS + NUM_ILLEGAL;
    localparam int TIMEOUT     = (TOTAL_OPS + 20) * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    funct6_e     funct6;
    sew_e        vsew;
    logic        vm;
    logic [7:0]  v0_mask;
    logic [63:0] vs2;
    logic [63:0] vs1;
    logic [63:0] vd_old;
    logic        out_valid;
    logic        out_illegal;
    logic [63:0] out_data;

    logic [31:0] lfsr_state = 32'd72779;
    int          op_count = 0;
    int          fails;
    funct6_e     op_list [6] = '{VAND, VOR, VXOR, VSLL, VSRL, VSRA};
    logic [5:0]  bad_codes [NUM_ILLEGAL] = '{6'b000000, FUNCT6_ILLEGAL, 6'b001000,
                                            6'b001100, 6'b100100, 6'b101010};

    riscv_v_logic_unit #(
        .LANE_BYTES(8)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .funct6     (funct6),
        .vsew       (vsew),
        .vm         (vm),
        .v0_mask    (v0_mask),
        .vs2        (vs2),
        .vs1        (vs1),
        .vd_old     (vd_old),
        .out_valid  (out_valid),
        .out_illegal(out_illegal),
        .out_data   (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic issue_op(input logic [5:0] f6, input logic [1:0] sew, input logic vm_bit);
        logic [63:0] r;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        funct6   = funct6_e'(f6);
        vsew     = sew_e'(sew);
        vm       = vm_bit;
        draw_bits(8, r);
        v0_mask = r[7:0];
        draw_bits(64, r);
        vs2 = r;
        draw_bits(64, r);
        vs1 = r;
        draw_bits(64, r);
        vd_old = r;
        op_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        funct6   = VAND;
        vsew     = E8;
        vm       = 1'b1;
        v0_mask  = '0;
        vs2      = '0;
        vs1      = '0;
        vd_old   = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Back-to-back at first, short gaps later on
        for (int i = 0; i < NUM_OPS; i++) begin
            case (i)
                120: idle_cycles(1);
                180: idle_cycles(2);
                240: idle_cycles(3);
                default: ;
            endcase
            issue_op(op_list[i % 6], 2'((i / 6) % 4), 1'((i / 24) % 2));
        end
        for (int k = 0; k < NUM_ILLEGAL; k++) begin
            issue_op(bad_codes[k], 2'(k % 4), 1'(k % 2));
        end
        idle_cycles(6);

        fails = int'(dut_i.checker_i.fail_count);
        $display("Operations issued: %0d, assertion failures: %0d", op_count, fails);
        if (fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : riscv_v_logic_tb

/* build.f */
hdl/riscv_pkg.sv
hdl/riscv_v_pkg.sv
hdl/riscv_v_decode.sv
hdl/riscv_v_bw_logic.sv
hdl/riscv_v_shifter.sv
hdl/riscv_v_logic_alu.sv
hdl/riscv_v_writeback.sv
hdl/riscv_v_logic_unit.sv
verification/riscv_v_logic_checker.sv
verification/riscv_v_logic_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for failures
verilator --binary --timing --assert -Wno-fatal --top-module riscv_v_logic_tb \
    -f build.f > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vriscv_v_logic_tb +verilator+error+limit+10000 > sim.log 2>&1 \
    || echo "ERRORS FOUND" >> sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }
